/* decode_pkg.sv */
// Shared types and constants for the RV32IM decode stage
`default_nettype none

package decode_pkg;

	localparam int W_ADDR    = 32;
	localparam int W_DATA    = 32;
	localparam int W_REGADDR = 5;

	localparam logic [W_ADDR-1:0] RESET_VECTOR = 32'h0000_0040;

	// ------------------------------------------------------------
	// Major opcodes and function fields

	localparam logic [6:0] OPC_LOAD     = 7'b0000011;
	localparam logic [6:0] OPC_STORE    = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
	localparam logic [6:0] OPC_JAL      = 7'b1101111;
	localparam logic [6:0] OPC_JALR     = 7'b1100111;
	localparam logic [6:0] OPC_OP       = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
	localparam logic [6:0] OPC_LUI      = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
	localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;
	localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;

	localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
	localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;
	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

	// SYSTEM words are matched in full, all other fields must be zero
	localparam logic [31:0] INSTR_ECALL  = 32'h0000_0073;
	localparam logic [31:0] INSTR_EBREAK = 32'h0010_0073;

	// ------------------------------------------------------------
	// Control encodings seen by execute

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_LT, ALU_LTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_RS2, ALU_MULDIV
	} alu_op_e;

	typedef enum logic [3:0] {
		MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU, MEM_SB, MEM_SH, MEM_SW
	} mem_op_e;

	// Ordered so that funct3 of an M instruction is its own code
	typedef enum logic [2:0] {
		MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU, MUL_DIV, MUL_DIVU, MUL_REM, MUL_REMU
	} mul_op_e;

	typedef enum logic [1:0] {BCOND_NEVER, BCOND_ZERO, BCOND_NZERO, BCOND_ALWAYS} bcond_e;
	typedef enum logic {SRCA_RS1, SRCA_PC} alusrc_a_e;
	typedef enum logic {SRCB_RS2, SRCB_IMM} alusrc_b_e;

	typedef enum logic [2:0] {
		EXC_NONE, EXC_ECALL, EXC_EBREAK, EXC_INSTR_ILLEGAL, EXC_INSTR_FAULT
	} except_e;

	// ------------------------------------------------------------
	// Instruction word, seen as register form or immediate form

	typedef struct packed {
		logic [6:0]           funct7;
		logic [W_REGADDR-1:0] rs2;
		logic [W_REGADDR-1:0] rs1;
		logic [2:0]           funct3;
		logic [W_REGADDR-1:0] rd;
		logic [6:0]           opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0]          imm12;
		logic [W_REGADDR-1:0] rs1;
		logic [2:0]           funct3;
		logic [W_REGADDR-1:0] rd;
		logic [6:0]           opcode;
	} i_fmt_t;

	typedef union packed {
		r_fmt_t r_view;
		i_fmt_t i_view;
	} instr_u;

	// ------------------------------------------------------------
	// Port bundles

	// vld counts valid halfwords, err flags a bus error per halfword
	typedef struct packed {
		logic [31:0] cir;
		logic [1:0]  err;
		logic [1:0]  vld;
	} fetch_t;

	typedef struct packed {
		logic              now;
		logic [W_ADDR-1:0] target;
		logic              not_except;
	} jump_t;

	typedef struct packed {
		logic [W_REGADDR-1:0] rs1;
		logic [W_REGADDR-1:0] rs2;
		logic [W_REGADDR-1:0] rd;
		logic [W_DATA-1:0]    imm;
		alusrc_a_e            alusrc_a;
		alusrc_b_e            alusrc_b;
		alu_op_e              aluop;
		mem_op_e              memop;
		mul_op_e              mulop;
		bcond_e               branchcond;
		logic                 addr_is_regoffs;
		except_e              except;
	} decode_ctrl_t;

endpackage

`default_nettype wire

/* decode_imm_gen.sv */
// Immediate generator: builds the five RV32 immediates and picks the address offset
`default_nettype none
`timescale 1ns/10ps

module decode_imm_gen (
	input  decode_pkg::instr_u                 instr_i,
	output logic [decode_pkg::W_DATA-1:0]      imm_i_o,
	output logic [decode_pkg::W_DATA-1:0]      imm_s_o,
	output logic [decode_pkg::W_DATA-1:0]      imm_b_o,
	output logic [decode_pkg::W_DATA-1:0]      imm_u_o,
	output logic [decode_pkg::W_DATA-1:0]      imm_j_o,
	output logic [decode_pkg::W_ADDR-1:0]      addr_offs_o
);

	import decode_pkg::*;

	// Bit 31 of the word is always the sign, funct7[6] in the register view
	assign imm_i_o = {{20{instr_i.i_view.imm12[11]}}, instr_i.i_view.imm12};

	assign imm_s_o = {{20{instr_i.r_view.funct7[6]}}, instr_i.r_view.funct7,
		instr_i.r_view.rd};

	assign imm_b_o = {{19{instr_i.r_view.funct7[6]}}, instr_i.r_view.funct7[6],
		instr_i.r_view.rd[0], instr_i.r_view.funct7[5:0], instr_i.r_view.rd[4:1], 1'b0};

	assign imm_u_o = {instr_i.r_view.funct7, instr_i.r_view.rs2, instr_i.r_view.rs1,
		instr_i.r_view.funct3, 12'h000};

	// J format scatters imm[19:12] over rs1 and funct3, imm[11] sits at rs2[0]
	assign imm_j_o = {{11{instr_i.r_view.funct7[6]}}, instr_i.r_view.funct7[6],
		instr_i.r_view.rs1, instr_i.r_view.funct3, instr_i.r_view.rs2[0],
		instr_i.r_view.funct7[5:0], instr_i.r_view.rs2[4:1], 1'b0};

	// Offset added to PC or rs1 by the address generator
	always_comb begin
		case (instr_i.r_view.opcode)
			OPC_JAL:    addr_offs_o = imm_j_o;
			OPC_BRANCH: addr_offs_o = imm_b_o;
			OPC_STORE:  addr_offs_o = imm_s_o;
			OPC_JALR:   addr_offs_o = imm_i_o;
			OPC_LOAD:   addr_offs_o = imm_i_o;
			default:    addr_offs_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* decode_fetch_ctrl.sv */
// Fetch buffer control: starvation, stall, buffer use, fetch fault and buffer lock
`default_nettype none
`timescale 1ns/10ps

module decode_fetch_ctrl (
	input  logic                clk,
	input  logic                rst_n,

	input  decode_pkg::fetch_t  fetch_i,
	input  logic                x_stall_i,
	input  logic                jump_now_i,
	input  logic                jump_not_except_i,

	output logic                starved_o,
	output logic                stall_o,
	output logic [1:0]          cir_use_o,
	output logic                cir_lock_o,
	output logic                lock_prev_o,
	output logic                fetch_fault_o
);

	logic lock_assert;
	logic lock_prev_q;

	// ------------------------------------------------------------
	// Buffer occupancy and consumption

	// Every instruction is two halfwords, so one valid halfword is not enough
	assign starved_o = fetch_i.vld < 2'd2;
	assign stall_o   = x_stall_i || starved_o;

	assign cir_use_o = stall_o ? 2'd0 : 2'd2;

	// Errors count only on halfwords that belong to the instruction. A fault
	// further down the buffer may still be flushed by a taken jump
	assign fetch_fault_o = (fetch_i.vld > 2'd0 && fetch_i.err[0]) ||
		(fetch_i.vld > 2'd1 && fetch_i.err[1]);

	// ------------------------------------------------------------
	// Buffer lock

	// A jump raised by the instruction in decode while it is held up by execute.
	// Without the lock, new fetch data would overwrite the instruction before
	// its link write or branch recovery has gone through
	assign lock_assert = jump_now_i && jump_not_except_i && stall_o;

	// The lock drops as soon as the stall clears
	assign cir_lock_o = (lock_prev_q && stall_o) || lock_assert;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lock_prev_q <= 1'b0;
		end else begin
			lock_prev_q <= cir_lock_o;
		end
	end

	assign lock_prev_o = lock_prev_q;

endmodule

`default_nettype wire

/* decode_pc.sv */
// Decode program counter: reset vector, jump load and sequential step of 4
`default_nettype none
`timescale 1ns/10ps

module decode_pc (
	input  logic                          clk,
	input  logic                          rst_n,

	input  logic                          jump_now_i,
	input  logic [decode_pkg::W_ADDR-1:0] jump_target_i,
	input  logic                          stall_i,
	input  logic                          cir_lock_i,
	input  logic                          lock_prev_i,

	output logic [decode_pkg::W_ADDR-1:0] pc_o
);

	import decode_pkg::*;

	logic [W_ADDR-1:0] pc_q;
	logic              lock_new;
	logic              lock_release;
	logic              load_target;

	// A lock that was not there last cycle was raised by this jump
	assign lock_new     = cir_lock_i && !lock_prev_i;
	assign lock_release = lock_prev_i && !stall_i;

	// On release the jump source still presents the deferred target
	assign load_target = (jump_now_i && !lock_new) || lock_release;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q <= RESET_VECTOR;
		end else if (load_target) begin
			pc_q <= jump_target_i;
		end else if (!stall_i && !cir_lock_i) begin
			pc_q <= pc_q + W_ADDR'(4);
		end
	end

	assign pc_o = pc_q;

endmodule

`default_nettype wire

/* decode_op_table.sv */
// Opcode decoder: maps RV32IM words to execute controls and raises decode exceptions
`default_nettype none
`timescale 1ns/10ps

module decode_op_table (
	input  decode_pkg::instr_u            instr_i,
	input  logic [decode_pkg::W_DATA-1:0] imm_i_i,
	input  logic [decode_pkg::W_DATA-1:0] imm_u_i,
	input  logic                          starved_i,
	input  logic                          fetch_fault_i,
	input  logic                          lock_prev_i,
	output decode_pkg::decode_ctrl_t      ctrl_o
);

	import decode_pkg::*;

	localparam logic [W_REGADDR-1:0] X0 = '0;

	decode_ctrl_t ctrl;
	logic         invalid;

	// Shared by OP and OP-IMM for the base funct7 encodings
	function automatic alu_op_e base_aluop(input logic [2:0] funct3);
		case (funct3)
			3'b000:  return ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_LT;
			3'b011:  return ALU_LTU;
			3'b100:  return ALU_XOR;
			3'b101:  return ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	always_comb begin
		ctrl.rs1             = instr_i.r_view.rs1;
		ctrl.rs2             = instr_i.r_view.rs2;
		ctrl.rd              = instr_i.r_view.rd;
		ctrl.imm             = imm_i_i;
		ctrl.alusrc_a        = SRCA_RS1;
		ctrl.alusrc_b        = SRCB_RS2;
		ctrl.aluop           = ALU_ADD;
		ctrl.memop           = MEM_NONE;
		ctrl.mulop           = MUL_MUL;
		ctrl.branchcond      = BCOND_NEVER;
		ctrl.addr_is_regoffs = 1'b0;
		ctrl.except          = EXC_NONE;
		invalid              = 1'b0;

		case (instr_i.r_view.opcode)
			OPC_BRANCH: begin
				// funct3[2:1] picks the compare, the xor with bit 0 picks the sense
				ctrl.rd = X0;
				case (instr_i.r_view.funct3[2:1])
					2'b00:   ctrl.aluop = ALU_SUB;
					2'b10:   ctrl.aluop = ALU_LT;
					2'b11:   ctrl.aluop = ALU_LTU;
					default: invalid = 1'b1;
				endcase
				ctrl.branchcond = (instr_i.r_view.funct3[0] ^ instr_i.r_view.funct3[2]) ?
					BCOND_NZERO : BCOND_ZERO;
			end
			OPC_JAL, OPC_JALR: begin
				// The ALU computes the link address, the jump target comes from addr_offs
				invalid = instr_i.r_view.opcode == OPC_JALR && instr_i.i_view.funct3 != 3'b000;
				ctrl.branchcond      = BCOND_ALWAYS;
				ctrl.addr_is_regoffs = instr_i.r_view.opcode == OPC_JALR;
				ctrl.rs2             = X0;
				ctrl.alusrc_a        = SRCA_PC;
				ctrl.alusrc_b        = SRCB_IMM;
				ctrl.imm             = W_DATA'(4);
				if (instr_i.r_view.opcode == OPC_JAL)
					ctrl.rs1 = X0;
			end
			OPC_LUI, OPC_AUIPC: begin
				ctrl.imm      = imm_u_i;
				ctrl.alusrc_b = SRCB_IMM;
				ctrl.rs1      = X0;
				ctrl.rs2      = X0;
				if (instr_i.r_view.opcode == OPC_AUIPC)
					ctrl.alusrc_a = SRCA_PC;
			end
			OPC_OP_IMM: begin
				ctrl.alusrc_b = SRCB_IMM;
				ctrl.rs2      = X0;
				case (instr_i.i_view.funct3)
					3'b001: begin
						ctrl.aluop = ALU_SLL;
						invalid    = instr_i.r_view.funct7 != FUNCT7_BASE;
					end
					3'b101: begin
						ctrl.aluop = instr_i.r_view.funct7 == FUNCT7_ALT ? ALU_SRA : ALU_SRL;
						invalid    = instr_i.r_view.funct7 != FUNCT7_BASE &&
							instr_i.r_view.funct7 != FUNCT7_ALT;
					end
					default: ctrl.aluop = base_aluop(instr_i.i_view.funct3);
				endcase
			end
			OPC_OP: begin
				if (instr_i.r_view.funct7 == FUNCT7_MULDIV) begin
					ctrl.aluop = ALU_MULDIV;
					ctrl.mulop = mul_op_e'(instr_i.r_view.funct3);
				end else if (instr_i.r_view.funct7 == FUNCT7_BASE) begin
					ctrl.aluop = base_aluop(instr_i.r_view.funct3);
				end else if (instr_i.r_view.funct7 == FUNCT7_ALT &&
					instr_i.r_view.funct3 == 3'b000) begin
					ctrl.aluop = ALU_SUB;
				end else if (instr_i.r_view.funct7 == FUNCT7_ALT &&
					instr_i.r_view.funct3 == 3'b101) begin
					ctrl.aluop = ALU_SRA;
				end else begin
					invalid = 1'b1;
				end
			end
			OPC_LOAD: begin
				ctrl.addr_is_regoffs = 1'b1;
				ctrl.rs2             = X0;
				case (instr_i.i_view.funct3)
					3'b000:  ctrl.memop = MEM_LB;
					3'b001:  ctrl.memop = MEM_LH;
					3'b010:  ctrl.memop = MEM_LW;
					3'b100:  ctrl.memop = MEM_LBU;
					3'b101:  ctrl.memop = MEM_LHU;
					default: invalid = 1'b1;
				endcase
			end
			OPC_STORE: begin
				// rs2 passes through the ALU as store data
				ctrl.addr_is_regoffs = 1'b1;
				ctrl.aluop           = ALU_RS2;
				ctrl.rd              = X0;
				case (instr_i.r_view.funct3)
					3'b000:  ctrl.memop = MEM_SB;
					3'b001:  ctrl.memop = MEM_SH;
					3'b010:  ctrl.memop = MEM_SW;
					default: invalid = 1'b1;
				endcase
			end
			OPC_MISC_MEM: begin
				// FENCE has nothing to order in this core
				invalid  = instr_i.i_view.funct3 != 3'b000;
				ctrl.rs1 = X0;
				ctrl.rs2 = X0;
				ctrl.rd  = X0;
			end
			OPC_SYSTEM: begin
				ctrl.rs1 = X0;
				ctrl.rs2 = X0;
				ctrl.rd  = X0;
				if (instr_i == INSTR_ECALL)
					ctrl.except = EXC_ECALL;
				else if (instr_i == INSTR_EBREAK)
					ctrl.except = EXC_EBREAK;
				else
					invalid = 1'b1;
			end
			default: invalid = 1'b1;
		endcase

		// ------------------------------------------------------------
		// Squash anything that must not reach execute as a real operation
		if (invalid || starved_i || fetch_fault_i) begin
			ctrl.rs1        = X0;
			ctrl.rs2        = X0;
			ctrl.rd         = X0;
			ctrl.memop      = MEM_NONE;
			ctrl.branchcond = BCOND_NEVER;
			ctrl.aluop      = ALU_ADD;
			ctrl.except     = EXC_NONE;
			if (fetch_fault_i)
				ctrl.except = EXC_INSTR_FAULT;
			else if (invalid && !starved_i)
				ctrl.except = EXC_INSTR_ILLEGAL;
		end

		// The held instruction already jumped, it must not branch again
		if (lock_prev_i)
			ctrl.branchcond = BCOND_NEVER;
	end

	assign ctrl_o = ctrl;

endmodule

`default_nettype wire

/* rv_decode.sv */
// RV32IM decode stage: fetch buffer control, PC, immediates and opcode decode
`default_nettype none
`timescale 1ns/10ps

module rv_decode (
	input  logic                          clk,
	input  logic                          rst_n,

	input  decode_pkg::fetch_t            fetch_i,
	input  logic                          x_stall_i,
	input  decode_pkg::jump_t             jump_i,

	output logic [1:0]                    cir_use_o,
	output logic                          cir_lock_o,
	output logic                          starved_o,
	output logic [decode_pkg::W_ADDR-1:0] pc_o,
	output decode_pkg::decode_ctrl_t      ctrl_o,
	output logic [decode_pkg::W_ADDR-1:0] addr_offs_o
);

	import decode_pkg::*;

	logic              stall;
	logic              lock_prev;
	logic              fetch_fault;
	logic [W_DATA-1:0] imm_i;
	logic [W_DATA-1:0] imm_u;

	decode_imm_gen imm_gen_i (
		.instr_i     (fetch_i.cir),
		.imm_i_o     (imm_i),
		.imm_s_o     (),
		.imm_b_o     (),
		.imm_u_o     (imm_u),
		.imm_j_o     (),
		.addr_offs_o (addr_offs_o)
	);

	decode_fetch_ctrl fetch_ctrl_i (
		.clk               (clk),
		.rst_n             (rst_n),
		.fetch_i           (fetch_i),
		.x_stall_i         (x_stall_i),
		.jump_now_i        (jump_i.now),
		.jump_not_except_i (jump_i.not_except),
		.starved_o         (starved_o),
		.stall_o           (stall),
		.cir_use_o         (cir_use_o),
		.cir_lock_o        (cir_lock_o),
		.lock_prev_o       (lock_prev),
		.fetch_fault_o     (fetch_fault)
	);

	decode_pc pc_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.jump_now_i    (jump_i.now),
		.jump_target_i (jump_i.target),
		.stall_i       (stall),
		.cir_lock_i    (cir_lock_o),
		.lock_prev_i   (lock_prev),
		.pc_o          (pc_o)
	);

	decode_op_table op_table_i (
		.instr_i       (fetch_i.cir),
		.imm_i_i       (imm_i),
		.imm_u_i       (imm_u),
		.starved_i     (starved_o),
		.fetch_fault_i (fetch_fault),
		.lock_prev_i   (lock_prev),
		.ctrl_o        (ctrl_o)
	);

endmodule

`default_nettype wire

/* rv_decode_properties.sv */
// Concurrent checks on the decode stage top level, attached to rv_decode by bind
`default_nettype none
`timescale 1ns/10ps

module rv_decode_properties (
	input logic                     clk,
	input logic                     rst_n,
	input logic                     x_stall_i,
	input decode_pkg::jump_t        jump_i,
	input logic [1:0]               cir_use_i,
	input logic                     cir_lock_i,
	input logic                     starved_i,
	input decode_pkg::decode_ctrl_t ctrl_i
);

	import decode_pkg::*;

	// Decode consumes the buffer only with a whole instruction and execute ready
	a_use_needs_flow: assert property (@(posedge clk) disable iff (!rst_n)
		cir_use_i != 2'd0 |-> !starved_i && !x_stall_i)
		else $error("buffer consumed while starved or stalled by execute");

	// A partial instruction is never illegal, it can only carry a bus fault
	a_starved_except: assert property (@(posedge clk) disable iff (!rst_n)
		starved_i |-> ctrl_i.except == EXC_NONE || ctrl_i.except == EXC_INSTR_FAULT)
		else $error("starved instruction raised a decode exception other than a fetch fault");

	a_no_lock_after_reset: assert property (@(posedge clk)
		$rose(rst_n) && !jump_i.now |-> !cir_lock_i)
		else $error("buffer lock high in the first cycle after reset without a jump");

endmodule

`default_nettype wire

/* tb_rv_decode.sv */
// Testbench for the RV32IM decode stage, driven by vectors from a stimulus file
`default_nettype none
`timescale 1ns/10ps

module tb_rv_decode;

	import decode_pkg::*;

	typedef struct packed {
		fetch_t            fetch;
		logic              x_stall;
		jump_t             jump;
		logic [1:0]        cir_use;
		logic              cir_lock;
		logic [W_ADDR-1:0] pc;
		decode_ctrl_t      ctrl;
		logic [W_ADDR-1:0] offs;
	} vector_t;

	logic              clk = 1'b0;
	logic              rst_n;
	fetch_t            fetch_i;
	logic              x_stall_i;
	jump_t             jump_i;
	logic [1:0]        cir_use_o;
	logic              cir_lock_o;
	logic              starved_o;
	logic [W_ADDR-1:0] pc_o;
	decode_ctrl_t      ctrl_o;
	logic [W_ADDR-1:0] addr_offs_o;

	vector_t vectors[$];
	int      errors = 0;
	int      watchdog_ns = 0;

	always #5 clk = ~clk;

	rv_decode rv_decode_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.fetch_i     (fetch_i),
		.x_stall_i   (x_stall_i),
		.jump_i      (jump_i),
		.cir_use_o   (cir_use_o),
		.cir_lock_o  (cir_lock_o),
		.starved_o   (starved_o),
		.pc_o        (pc_o),
		.ctrl_o      (ctrl_o),
		.addr_offs_o (addr_offs_o)
	);

	bind rv_decode rv_decode_properties props_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.x_stall_i  (x_stall_i),
		.jump_i     (jump_i),
		.cir_use_i  (cir_use_o),
		.cir_lock_i (cir_lock_o),
		.starved_i  (starved_o),
		.ctrl_i     (ctrl_o)
	);

	// ------------------------------------------------------------
	// Compare tasks

	task automatic check_ctrl(input string name, input decode_ctrl_t exp, input decode_ctrl_t act);
		if (act !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input logic [W_ADDR-1:0] exp,
		input logic [W_ADDR-1:0] act);
		if (act !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
		end
	endtask

	// ------------------------------------------------------------
	// Vector file and drivers

	task automatic load_vectors();
		int          fd;
		int          n;
		string       line;
		logic [31:0] f [0:22];
		vector_t     v;
		fd = $fopen("rv_decode_stim.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Cannot open the stimulus file rv_decode_stim.txt");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) == 0)
				break;
			// Comment and blank lines carry no vector
			if (line.len() < 2 || line[0] == "#")
				continue;
			n = $sscanf(line,
				"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
				f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21], f[22]);
			if (n != 23) begin
				errors++;
				$display("Stimulus line has %0d fields instead of 23: %s", n, line);
				continue;
			end
			v.fetch.cir            = f[0];
			v.fetch.err            = f[1][1:0];
			v.fetch.vld            = f[2][1:0];
			v.x_stall              = f[3][0];
			v.jump.now             = f[4][0];
			v.jump.target          = f[5];
			v.jump.not_except      = f[6][0];
			v.cir_use              = f[7][1:0];
			v.cir_lock             = f[8][0];
			v.pc                   = f[9];
			v.ctrl.rs1             = f[10][W_REGADDR-1:0];
			v.ctrl.rs2             = f[11][W_REGADDR-1:0];
			v.ctrl.rd              = f[12][W_REGADDR-1:0];
			v.ctrl.imm             = f[13];
			v.ctrl.alusrc_a        = alusrc_a_e'(f[14][0]);
			v.ctrl.alusrc_b        = alusrc_b_e'(f[15][0]);
			v.ctrl.aluop           = alu_op_e'(f[16][3:0]);
			v.ctrl.memop           = mem_op_e'(f[17][3:0]);
			v.ctrl.mulop           = mul_op_e'(f[18][2:0]);
			v.ctrl.branchcond      = bcond_e'(f[19][1:0]);
			v.ctrl.addr_is_regoffs = f[20][0];
			v.ctrl.except          = except_e'(f[21][2:0]);
			v.offs                 = f[22];
			vectors.push_back(v);
		end
		$fclose(fd);
	endtask

	task automatic apply_vector(input vector_t v);
		@(posedge clk);
		fetch_i   <= v.fetch;
		x_stall_i <= v.x_stall;
		jump_i    <= v.jump;
	endtask

	// Stalled and empty, so neither the PC nor the lock history moves
	task automatic apply_idle();
		@(posedge clk);
		fetch_i   <= '0;
		x_stall_i <= 1'b1;
		jump_i    <= '0;
	endtask

	task automatic check_outputs(input vector_t v);
		logic starved_exp;
		starved_exp = v.fetch.vld < 2'd2;
		check_flag("cir_use_o", v.cir_use, cir_use_o);
		check_flag("cir_lock_o", {1'b0, v.cir_lock}, {1'b0, cir_lock_o});
		check_flag("starved_o", {1'b0, starved_exp}, {1'b0, starved_o});
		check_addr("pc_o", v.pc, pc_o);
		check_ctrl("ctrl_o", v.ctrl, ctrl_o);
		check_addr("addr_offs_o", v.offs, addr_offs_o);
	endtask

	// ------------------------------------------------------------
	// Main sequence

	initial begin
		int idle_cycles;
		rst_n     = 1'b0;
		fetch_i   = '0;
		x_stall_i = 1'b0;
		jump_i    = '0;
		void'($urandom(32'h6868edb0));
		load_vectors();
		if (vectors.size() == 0) begin
			errors++;
			$display("No test vectors were read from the stimulus file");
		end
		// Each vector takes one cycle plus up to two idle cycles
		watchdog_ns = vectors.size() * 30 + 80 + 200;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		foreach (vectors[i]) begin
			apply_vector(vectors[i]);
			@(negedge clk);
			check_outputs(vectors[i]);
			idle_cycles = $urandom % 3;
			repeat (idle_cycles) apply_idle();
		end
		@(posedge clk);
		$display("Checked %0d vectors with %0d errors", vectors.size(), errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	initial begin
		wait (watchdog_ns != 0);
		#(watchdog_ns);
		$display("Watchdog expired after %0d ns before all vectors were checked", watchdog_ns);
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

/* rv_decode_stim.txt */
# cir err vld x_stall jump_now jump_target jump_not_except | expected: cir_use cir_lock pc
# rs1 rs2 rd imm alusrc_a alusrc_b aluop memop mulop branchcond addr_is_regoffs except addr_offs
00510093 0 2 0 0 00000000 0 2 0 00000040 02 00 01 00000005 0 1 0 0 0 0 0 0 00000000
405201B3 0 2 0 0 00000000 0 2 0 00000044 04 05 03 00000405 0 0 1 0 0 0 0 0 00000000
4083D333 0 2 0 0 00000000 0 2 0 00000048 07 08 06 00000408 0 0 7 0 0 0 0 0 00000000
00B534B3 0 2 0 0 00000000 0 2 0 0000004C 0A 0B 09 0000000B 0 0 4 0 0 0 0 0 00000000
FF86A603 0 2 0 0 00000000 0 2 0 00000050 0D 00 0C FFFFFFF8 0 0 0 3 0 0 1 0 FFFFFFF8
06F71F23 0 2 0 0 00000000 0 2 0 00000054 0E 0F 00 0000006F 0 0 A 7 0 0 1 0 0000007E
FF1818E3 0 2 0 0 00000000 0 2 0 00000058 10 11 00 FFFFFFF1 0 0 1 0 0 2 0 0 FFFFFFF0
01395463 0 2 0 0 00000000 0 2 0 0000005C 12 13 00 00000013 0 0 3 0 0 1 0 0 00000008
036A8A33 0 2 0 0 00000000 0 2 0 00000060 15 16 14 00000036 0 0 B 0 0 0 0 0 00000000
039C5BB3 0 2 0 0 00000000 0 2 0 00000064 18 19 17 00000039 0 0 B 0 5 0 0 0 00000000
03CDFD33 0 2 0 0 00000000 0 2 0 00000068 1B 1C 1A 0000003C 0 0 B 0 7 0 0 0 00000000
123452B7 0 2 0 0 00000000 0 2 0 0000006C 00 00 05 12345000 0 1 0 0 0 0 0 0 00000000
FFFFF317 0 2 0 0 00000000 0 2 0 00000070 00 00 06 FFFFF000 1 1 0 0 0 0 0 0 00000000
00C280E7 0 2 0 0 00000000 0 2 0 00000074 05 00 01 00000004 1 1 0 0 0 3 1 0 0000000C
001000EF 0 2 0 0 00000000 0 2 0 00000078 00 00 01 00000004 1 1 0 0 0 3 0 0 00000800
00000073 0 2 0 0 00000000 0 2 0 0000007C 00 00 00 00000000 0 0 0 0 0 0 0 1 00000000
00100073 0 2 0 0 00000000 0 2 0 00000080 00 00 00 00000001 0 0 0 0 0 0 0 2 00000000
12345678 0 2 0 0 00000000 0 2 0 00000084 00 00 00 00000123 0 0 0 0 0 0 0 3 00000000
00510093 1 2 0 0 00000000 0 2 0 00000088 00 00 00 00000005 0 1 0 0 0 0 0 4 00000000
405201B3 0 1 0 0 00000000 0 0 0 0000008C 00 00 00 00000405 0 0 0 0 0 0 0 0 00000000
405201B3 1 1 0 0 00000000 0 0 0 0000008C 00 00 00 00000405 0 0 0 0 0 0 0 4 00000000
FF86A603 0 2 1 0 00000000 0 0 0 0000008C 0D 00 0C FFFFFFF8 0 0 0 3 0 0 1 0 FFFFFFF8
FF86A603 0 2 0 0 00000000 0 2 0 0000008C 0D 00 0C FFFFFFF8 0 0 0 3 0 0 1 0 FFFFFFF8
00208863 0 2 1 1 00000200 1 0 1 00000090 01 02 00 00000002 0 0 1 0 0 1 0 0 00000010
00208863 0 2 1 0 00000000 0 0 1 00000090 01 02 00 00000002 0 0 1 0 0 0 0 0 00000010
00208863 0 2 0 0 00000200 0 2 0 00000090 01 02 00 00000002 0 0 1 0 0 0 0 0 00000010
00510093 0 2 0 0 00000000 0 2 0 00000200 02 00 01 00000005 0 1 0 0 0 0 0 0 00000000
00510093 0 2 0 1 00000300 1 2 0 00000204 02 00 01 00000005 0 1 0 0 0 0 0 0 00000000
00510093 0 2 0 0 00000000 0 2 0 00000300 02 00 01 00000005 0 1 0 0 0 0 0 0 00000000
00510093 2 2 0 0 00000000 0 2 0 00000304 00 00 00 00000005 0 1 0 0 0 0 0 4 00000000
00510093 2 1 0 0 00000000 0 0 0 00000308 00 00 00 00000005 0 1 0 0 0 0 0 0 00000000

/* rv_decode.f */
decode_pkg.sv
decode_imm_gen.sv
decode_fetch_ctrl.sv
decode_pc.sv
decode_op_table.sv
rv_decode.sv
rv_decode_properties.sv
tb_rv_decode.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the decode stage simulation with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f rv_decode.f --top-module tb_rv_decode \
	-o sim_tb_rv_decode \
	&& ./obj_dir/sim_tb_rv_decode | tee /dev/stderr | grep -qx "sim passed" \
	&& echo "RESULT: PASS" \
	|| { echo "RESULT: FAIL"; exit 1; }
